/* src/stackPkg.sv */
// stack package
// op and status codes, command word layout, AXI4-Lite channel bundles
`default_nettype none

package stackPkg;

  typedef enum logic [1:0] {
    opNone       = 2'd0, // refresh top and status only
    opPush       = 2'd1,
    opPop        = 2'd2, // removes count + 1 frames
    opIndexReset = 2'd3
  } stackOp;

  typedef enum logic [2:0] {
    statNone      = 3'd0,
    statEmpty     = 3'd1, // reset value
    statFull      = 3'd2,
    statUnderflow = 3'd3,
    statOverflow  = 3'd4,
    statBadIndex  = 3'd5
  } stackStatus;

  // argument field, meaning depends on op
  typedef union packed {
    logic [15:0] value;    // push data or extra pop count
    logic [15:0] newIndex; // indexReset target
  } stackArg;

  typedef struct packed {
    stackOp      op;       // bits 31:30
    logic [13:0] reserved;
    stackArg     arg;      // bits 15:0
  } stackCmd;

  // master driven write side
  typedef struct packed {
    logic        awvalid;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
  } axiLiteWrite;

  // master driven read side
  typedef struct packed {
    logic       arvalid;
    logic [3:0] araddr;
    logic       rready;
  } axiLiteRead;

  // everything the slave drives
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axiLiteResp;

  localparam logic [3:0] regCommand = 4'h0; // write only
  localparam logic [3:0] regStatus  = 4'h4; // read only
  localparam logic [3:0] regTop     = 4'h8; // read only
  localparam logic [3:0] regLimit   = 4'hC; // read and write

  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

endpackage

`default_nettype wire

/* src/limitedStack.sv */
// bounded stack core
// frame array with push, multi-word pop, index reset and underflow limit
`default_nettype none

module limitedStack #(
  parameter int dataWidth = 8, // bits per frame
  parameter int depthBits = 7  // index is depthBits + 1 wide
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      cmdValid, // one command per pulse
  input  wire stackPkg::stackCmd   cmd,
  input  wire [depthBits:0]        limit,    // frames below are protected
  output logic [depthBits:0]       index,    // next free frame
  output logic [dataWidth-1:0]     top,      // frame below index
  output stackPkg::stackStatus     status
);

  localparam logic [depthBits:0] maxIndex = '1;

  logic [dataWidth-1:0] frames [0:maxIndex-1];

  logic                 accept;     // command takes effect
  logic [depthBits:0]   nextIndex;
  stackPkg::stackStatus refuseCode;
  logic [17:0]          popSpan;    // count + 1, wide enough for no wrap

  // sticky refusal, shown until next command or a limit change
  logic                 errValid;
  stackPkg::stackStatus errCode;
  logic [depthBits:0]   errLimit;

  // level status from an index, full wins over empty
  function automatic stackPkg::stackStatus levelStatus(
    input logic [depthBits:0] idx,
    input logic [depthBits:0] lim
  );
    if (idx == maxIndex)
      return stackPkg::statFull;
    else if (idx == lim)
      return stackPkg::statEmpty;
    else if (idx < lim)
      return stackPkg::statUnderflow;
    else
      return stackPkg::statNone;
  endfunction

  // decide the command outcome
  always_comb begin
    accept     = 1'b1;
    nextIndex  = index;
    refuseCode = stackPkg::statNone;
    popSpan    = 18'(cmd.arg.value) + 18'd1;
    case (cmd.op)
      stackPkg::opPush: begin
        if (index == maxIndex) begin
          accept     = 1'b0;
          refuseCode = stackPkg::statOverflow;
        end else begin
          nextIndex = index + 1'b1;
        end
      end
      stackPkg::opPop: begin
        // index - span < limit, kept in wide unsigned form
        if (18'(index) < 18'(limit) + popSpan) begin
          accept     = 1'b0;
          refuseCode = stackPkg::statUnderflow;
        end else begin
          nextIndex = index - popSpan[depthBits:0];
        end
      end
      stackPkg::opIndexReset: begin
        if (cmd.arg.newIndex > 16'(index)) begin // only downwards
          accept     = 1'b0;
          refuseCode = stackPkg::statBadIndex;
        end else begin
          nextIndex = cmd.arg.newIndex[depthBits:0];
        end
      end
      stackPkg::opNone: ; // index kept, top and status refreshed
      default: ;
    endcase
  end

  // index and refusal state
  always_ff @(posedge clk) begin
    if (reset) begin
      index    <= '0;
      errValid <= 1'b0; // status falls back to empty
      errCode  <= stackPkg::statNone;
      errLimit <= '0;
    end else if (cmdValid) begin
      if (accept) begin
        index    <= nextIndex;
        errValid <= 1'b0;
      end else begin
        errValid <= 1'b1;
        errCode  <= refuseCode;
        errLimit <= limit; // a new limit retires the error
      end
    end
  end

  // frames and top of stack
  always_ff @(posedge clk) begin
    if (cmdValid && accept) begin
      if (cmd.op == stackPkg::opPush) begin
        frames[index] <= cmd.arg.value[dataWidth-1:0];
        top           <= cmd.arg.value[dataWidth-1:0]; // forwarded
      end else if (nextIndex == '0) begin
        top <= '0; // nothing below
      end else begin
        top <= frames[nextIndex - 1'b1];
      end
    end
  end

  assign status = (errValid && errLimit == limit) ? errCode : levelStatus(index, limit);

  // index climbs one frame at a time, so it cannot wrap at either end
  indexNoWrap: assert property (@(posedge clk) disable iff (reset)
    index > $past(index) |-> index == $past(index) + 1'b1);

  // refused commands leave the index alone
  refuseKeepsIndex: assert property (@(posedge clk) disable iff (reset)
    cmdValid && !accept |=> $stable(index));

endmodule

`default_nettype wire

/* src/stackBusSlave.sv */
// AXI4-Lite slave for the stack
// register writes become command pulses, reads return status, top and limit
`default_nettype none

module stackBusSlave #(
  parameter int depthBits = 7
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire stackPkg::axiLiteWrite busWrite,
  input  wire stackPkg::axiLiteRead  busRead,
  output stackPkg::axiLiteResp       busResp,
  output logic                       cmdValid, // one cycle after accept
  output stackPkg::stackCmd          cmd,
  output logic [depthBits:0]         limit,
  input  wire [depthBits:0]          index,
  input  wire [15:0]                 top,      // zero extended frame
  input  wire stackPkg::stackStatus  status
);

  logic        writeAccept;
  logic        readAccept;
  logic        isCommand;
  logic        isLimit;
  logic [15:0] limitMerged; // limit after byte strobes
  logic        bvalid;
  logic [1:0]  bresp;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic [31:0] readWord;
  logic [1:0]  readResp;

  // address and data taken together, nothing pending
  assign writeAccept = busWrite.awvalid && busWrite.wvalid && !bvalid && !cmdValid;
  assign readAccept  = busRead.arvalid && !rvalid;
  assign isCommand   = busWrite.awaddr == stackPkg::regCommand;
  assign isLimit     = busWrite.awaddr == stackPkg::regLimit;

  always_comb begin
    limitMerged = 16'(limit);
    if (busWrite.wstrb[0])
      limitMerged[7:0] = busWrite.wdata[7:0];
    if (busWrite.wstrb[1])
      limitMerged[15:8] = busWrite.wdata[15:8];
  end

  // read mux, sampled in the accept cycle
  always_comb begin
    readWord = '0;
    readResp = stackPkg::respOkay;
    case (busRead.araddr)
      stackPkg::regStatus: begin
        readWord[depthBits:0] = index;
        readWord[18:16]       = status;
      end
      stackPkg::regTop:   readWord[15:0]        = top;
      stackPkg::regLimit: readWord[depthBits:0] = limit;
      default:            readResp              = stackPkg::respSlvErr; // data stays 0
    endcase
  end

  // channel control
  always_ff @(posedge clk) begin
    if (reset) begin
      cmdValid <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
      limit    <= '0;
    end else begin
      cmdValid <= writeAccept && isCommand;
      // command answers after the core has applied it
      if (writeAccept && !isCommand)
        bvalid <= 1'b1;
      else if (cmdValid)
        bvalid <= 1'b1;
      else if (busWrite.bready)
        bvalid <= 1'b0;
      if (writeAccept && isLimit)
        limit <= limitMerged[depthBits:0];
      if (readAccept)
        rvalid <= 1'b1;
      else if (busRead.rready)
        rvalid <= 1'b0;
    end
  end

  // payload, held while valid waits
  always_ff @(posedge clk) begin
    if (writeAccept) begin
      if (isCommand)
        cmd <= stackPkg::stackCmd'(busWrite.wdata);
      bresp <= (isCommand || isLimit) ? stackPkg::respOkay : stackPkg::respSlvErr;
    end
    if (readAccept) begin
      rdata <= readWord;
      rresp <= readResp;
    end
  end

  always_comb begin
    busResp.awready = writeAccept;
    busResp.wready  = writeAccept; // same cycle as awready
    busResp.bvalid  = bvalid;
    busResp.bresp   = bresp;
    busResp.arready = !rvalid;
    busResp.rvalid  = rvalid;
    busResp.rdata   = rdata;
    busResp.rresp   = rresp;
  end

  // responses held until taken
  bValidHold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !busWrite.bready |=> bvalid);

  rValidHold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !busRead.rready |=> rvalid);

  // an accepted write leaves a response owed, never a second accept
  noAcceptPending: assert property (@(posedge clk) disable iff (reset)
    busResp.awready |=> (bvalid || cmdValid) && !busResp.awready);

endmodule

`default_nettype wire

/* src/stackTop.sv */
// stack top level
// AXI4-Lite slave in front of the bounded stack core
`default_nettype none

module stackTop #(
  parameter int dataWidth = 8, // at most 16
  parameter int depthBits = 7  // at most 14
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire stackPkg::axiLiteWrite busWrite,
  input  wire stackPkg::axiLiteRead  busRead,
  output stackPkg::axiLiteResp       busResp
);

  logic                 cmdValid;
  stackPkg::stackCmd    cmd;
  logic [depthBits:0]   limit;
  logic [depthBits:0]   index;
  logic [dataWidth-1:0] top;
  stackPkg::stackStatus status;

  stackBusSlave #(
    .depthBits(depthBits)
  ) busSlave (
    .clk     (clk),
    .reset   (reset),
    .busWrite(busWrite),
    .busRead (busRead),
    .busResp (busResp),
    .cmdValid(cmdValid),
    .cmd     (cmd),
    .limit   (limit),
    .index   (index),
    .top     (16'(top)), // widened to the register field
    .status  (status)
  );

  limitedStack #(
    .dataWidth(dataWidth),
    .depthBits(depthBits)
  ) stackCore (
    .clk     (clk),
    .reset   (reset),
    .cmdValid(cmdValid),
    .cmd     (cmd),
    .limit   (limit),
    .index   (index),
    .top     (top),
    .status  (status)
  );

endmodule

`default_nettype wire

/* sim/stackTb.sv */
// testbench for the AXI4-Lite stack
// runs bus transactions from the tests file and checks every response
`default_nettype none

module stackTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int maxTests = 64;

  // one line of the tests file
  typedef struct packed {
    logic [3:0]  kind;    // 1 write, 2 read
    logic [7:0]  count;   // repetitions, write data steps by one
    logic [3:0]  addr;
    logic [31:0] wdata;
    logic [31:0] expData; // reads only
    logic [3:0]  expResp;
  } testEntry;

  logic                  clk;
  logic                  reset;
  stackPkg::axiLiteWrite busWrite;
  stackPkg::axiLiteRead  busRead;
  stackPkg::axiLiteResp  busResp;

  logic [83:0] tests [0:maxTests-1];
  int          errors;
  int          cycles;
  int          cycleLimit;
  int          doneCount; // transactions finished
  logic [15:0] lfsrState;

  stackTop #(
    .dataWidth(8),
    .depthBits(7)
  ) DUT (
    .clk     (clk),
    .reset   (reset),
    .busWrite(busWrite),
    .busRead (busRead),
    .busResp (busResp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic randomBits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState); // one step per bit
      val = (val << 1) | lfsrState[0];
    end
  endtask

  task automatic checkValue(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %0t: %s got %h expected %h", $time, what, actual, expected);
      errors = errors + 1;
    end
  endtask

  task automatic endRun();
    $display("errors: %0d, transactions: %0d, cycles: %0d", errors, doneCount, cycles);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  endtask

  // address and data together, then a late bready
  task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int delay;
    busWrite.awvalid <= 1'b1;
    busWrite.awaddr  <= addr;
    busWrite.wvalid  <= 1'b1;
    busWrite.wdata   <= data;
    busWrite.wstrb   <= 4'hF;
    do @(posedge clk); while (!busResp.awready); // accepted at this edge
    checkValue("wready with awready", 32'(busResp.wready), 32'd1);
    busWrite.awvalid <= 1'b0;
    busWrite.wvalid  <= 1'b0;
    randomBits(2, delay);
    repeat (delay) @(posedge clk);
    busWrite.bready <= 1'b1;
    do @(posedge clk); while (!busResp.bvalid);
    resp = busResp.bresp;
    busWrite.bready <= 1'b0;
    @(posedge clk);
    checkValue("bvalid once only", 32'(busResp.bvalid), 32'd0);
  endtask

  task automatic readReg(input logic [3:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int delay;
    busRead.arvalid <= 1'b1;
    busRead.araddr  <= addr;
    do @(posedge clk); while (!busResp.arready);
    busRead.arvalid <= 1'b0;
    randomBits(2, delay); // 0 to 3 cycles of rready stall
    repeat (delay) @(posedge clk);
    busRead.rready <= 1'b1;
    do @(posedge clk); while (!busResp.rvalid);
    data = busResp.rdata;
    resp = busResp.rresp;
    busRead.rready <= 1'b0;
    @(posedge clk);
    checkValue("rvalid once only", 32'(busResp.rvalid), 32'd0);
  endtask

  // hang guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: tests did not finish within %0d cycles", cycleLimit);
      errors = errors + 1;
      endRun();
    end
  end

  initial begin
    testEntry    entry;
    int          numEntries;
    int          total;
    logic [31:0] data;
    logic [1:0]  resp;
    busWrite   = '0;
    busRead    = '0;
    reset      = 1'b1;
    errors     = 0;
    cycles     = 0;
    doneCount  = 0;
    lfsrState  = 16'd4; // seed
    numEntries = 0;
    total      = 0;
    for (int i = 0; i < maxTests; i++)
      tests[i] = '0; // kind 0 marks the end
    $readmemh("sim/stackTests.mem", tests);
    while (numEntries < maxTests) begin
      entry = testEntry'(tests[numEntries]);
      if (entry.kind == 4'd0)
        break;
      total      = total + entry.count;
      numEntries = numEntries + 1;
    end
    cycleLimit = 20 * total + 50;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int t = 0; t < numEntries; t++) begin
      entry = testEntry'(tests[t]);
      for (int r = 0; r < entry.count; r++) begin
        if (entry.kind == 4'd1) begin
          writeReg(entry.addr, entry.wdata + r, resp);
          checkValue($sformatf("test %0d write %h bresp", t, entry.addr),
                     32'(resp), 32'(entry.expResp));
        end else if (entry.kind == 4'd2) begin
          readReg(entry.addr, data, resp);
          checkValue($sformatf("test %0d read %h rdata", t, entry.addr), data, entry.expData);
          checkValue($sformatf("test %0d read %h rresp", t, entry.addr),
                     32'(resp), 32'(entry.expResp));
        end else begin
          $display("test %0d has an unknown access kind %0d", t, entry.kind);
          errors = errors + 1;
        end
        doneCount = doneCount + 1;
      end
    end
    endRun();
  end

endmodule

`default_nettype wire

/* sim/stackTests.mem */
// kind (1 write, 2 read) _ repeat count _ address _ write data _ expected rdata _ expected resp
// repeated writes add one to the write data on each repetition
2_01_4_00000000_00010000_0
1_01_0_400000A5_00000000_0
2_01_8_00000000_000000A5_0
2_01_4_00000000_00000001_0
1_05_0_40000011_00000000_0
2_01_4_00000000_00000006_0
1_01_0_80000002_00000000_0
2_01_4_00000000_00000003_0
2_01_8_00000000_00000012_0
1_01_C_00000003_00000000_0
2_01_4_00000000_00010003_0
1_01_0_40000077_00000000_0
1_01_0_80000001_00000000_0
2_01_4_00000000_00030004_0
2_01_8_00000000_00000077_0
1_01_C_00000000_00000000_0
1_01_0_C0000002_00000000_0
2_01_8_00000000_00000011_0
1_01_0_C0000005_00000000_0
2_01_4_00000000_00050002_0
1_01_0_C0000000_00000000_0
2_01_4_00000000_00010000_0
1_FF_0_40000000_00000000_0
2_01_4_00000000_000200FF_0
1_01_0_400000EE_00000000_0
2_01_4_00000000_000400FF_0
2_01_8_00000000_000000FE_0
1_01_8_40000055_00000000_2
2_01_0_00000000_00000000_2

/* filelist.f */
src/stackPkg.sv
src/limitedStack.sv
src/stackBusSlave.sv
src/stackTop.sv
sim/stackTb.sv
